//--- design/lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [5:0] {
        OP_ADD    = 6'd0,
        OP_SUB    = 6'd1,
        OP_AND    = 6'd2,
        OP_OR     = 6'd3,
        OP_MUL_LO = 6'd4,
        OP_MUL_HI = 6'd5,
        OP_LD_B   = 6'd8,
        OP_LD_H   = 6'd9,
        OP_LD_W   = 6'd10,
        OP_LD_BU  = 6'd11,
        OP_LD_HU  = 6'd12,
        OP_ST_B   = 6'd16,
        OP_ST_H   = 6'd17,
        OP_ST_W   = 6'd18
    } op_t;

    // register format
    typedef struct packed {
        op_t         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [10:0] unused;
    } r_fmt_t;

    // memory format, offset added to the base operand
    typedef struct packed {
        op_t                op;
        logic [4:0]         rd;
        logic [4:0]         rj;
        logic signed [15:0] imm;
    } m_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        m_fmt_t m_fmt;
    } insn_t;

    // load width
    typedef enum logic [1:0] {
        LD_BYTE = 2'd0,
        LD_HALF = 2'd1,
        LD_WORD = 2'd2
    } ld_size_t;

    typedef struct packed {
        logic [4:0]  dest;
        logic        gr_we;
        ld_size_t    ld_size;
        logic        ld_signed;
        logic        res_from_mem;
        logic [1:0]  addr_low;
        logic [31:0] alu_result;
    } es_ms_t;

    typedef struct packed {
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] final_result;
    } ms_ws_t;

endpackage

//--- design/stage_if.sv
interface es_ms_if import lsu_pkg::*; ();
    logic   valid;
    logic   allowin;
    es_ms_t bus;

    modport src (
        output valid,
        output bus,
        input  allowin
    );

    modport dst (
        input  valid,
        input  bus,
        output allowin
    );
endinterface

interface ms_ws_if import lsu_pkg::*; ();
    logic   valid;
    logic   allowin;
    ms_ws_t bus;

    modport src (
        output valid,
        output bus,
        input  allowin
    );

    modport dst (
        input  valid,
        input  bus,
        output allowin
    );
endinterface

//--- design/exe_stage.sv
module exe_stage import lsu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_allowin,
    input  insn_t             in_insn,
    input  logic [31:0]       in_src1,
    input  logic [31:0]       in_src2,
    es_ms_if.src              ms,
    output logic              ram_en,
    output logic [3:0]        ram_we,
    output logic [ADDR_W-1:0] ram_addr,
    output logic [31:0]       ram_wdata
);
    logic        es_valid;
    insn_t       insn_r;
    logic [31:0] src1_r;
    logic [31:0] src2_r;
    op_t         op;
    logic [63:0] product;
    logic [31:0] addr;
    logic        is_load;
    logic        is_store;
    logic [3:0]  byte_en;
    es_ms_t      es_bus;

    // never stalls internally
    assign in_allowin = !es_valid || ms.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
        if (in_valid && in_allowin) begin
            insn_r <= in_insn;
            src1_r <= in_src1;
            src2_r <= in_src2;
        end
    end

    assign op       = insn_r.r_fmt.op;
    assign is_load  = op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
    assign is_store = op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    assign product  = src1_r * src2_r;
    assign addr     = src1_r + {{16{insn_r.m_fmt.imm[15]}}, insn_r.m_fmt.imm};

    always_comb begin
        es_bus.dest         = insn_r.r_fmt.rd;
        es_bus.gr_we        = !is_store;
        es_bus.res_from_mem = is_load;
        es_bus.addr_low     = addr[1:0];
        es_bus.ld_signed    = (op == OP_LD_B) || (op == OP_LD_H);
        case (op)
            OP_LD_B, OP_LD_BU: es_bus.ld_size = LD_BYTE;
            OP_LD_H, OP_LD_HU: es_bus.ld_size = LD_HALF;
            default:           es_bus.ld_size = LD_WORD;
        endcase
        case (op)
            OP_ADD:    es_bus.alu_result = src1_r + src2_r;
            OP_SUB:    es_bus.alu_result = src1_r - src2_r;
            OP_AND:    es_bus.alu_result = src1_r & src2_r;
            OP_OR:     es_bus.alu_result = src1_r | src2_r;
            OP_MUL_LO: es_bus.alu_result = product[31:0];
            OP_MUL_HI: es_bus.alu_result = product[63:32];
            // loads and stores carry the address
            default:   es_bus.alu_result = addr;
        endcase
    end

    // lanes replicated so the byte enables pick the right one
    always_comb begin
        case (op)
            OP_ST_B: begin
                byte_en   = 4'b0001 << addr[1:0];
                ram_wdata = {4{src2_r[7:0]}};
            end
            OP_ST_H: begin
                byte_en   = addr[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{src2_r[15:0]}};
            end
            OP_ST_W: begin
                byte_en   = 4'b1111;
                ram_wdata = src2_r;
            end
            default: begin
                byte_en   = 4'b0000;
                ram_wdata = src2_r;
            end
        endcase
    end

    assign ram_en   = es_valid && is_load;
    assign ram_we   = (es_valid && ms.allowin) ? byte_en : 4'b0000;
    assign ram_addr = addr[ADDR_W+1:2];

    assign ms.valid = es_valid;
    assign ms.bus   = es_bus;
endmodule

//--- design/data_ram.sv
module data_ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              en,
    input  logic [3:0]        we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata
);
    logic [31:0] mem [0:2**ADDR_W-1];

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end
endmodule

//--- design/mem_stage.sv
module mem_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    es_ms_if.dst        es,
    ms_ws_if.src        ws,
    input  logic [31:0] rdata
);
    logic        ms_valid;
    logic        ms_first;
    logic        ms_allowin;
    es_ms_t      bus_r;
    logic [31:0] rdata_buf;
    logic [31:0] load_word;
    logic [7:0]  byte_data;
    logic [15:0] half_data;
    logic [31:0] mem_result;
    ms_ws_t      ws_bus;

    assign ms_allowin = !ms_valid || ws.allowin;
    assign es.allowin = ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es.valid;
        end
        if (es.valid && ms_allowin) begin
            bus_r <= es.bus;
        end
    end

    // ram output only holds the load's data right after the handoff
    always_ff @(posedge clk) begin
        if (reset) begin
            ms_first <= 1'b0;
        end else begin
            ms_first <= es.valid && ms_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && ms_first && !ws.allowin) begin
            rdata_buf <= rdata;
        end
    end

    assign load_word = ms_first ? rdata : rdata_buf;

    always_comb begin
        case (bus_r.addr_low)
            2'd0:    byte_data = load_word[7:0];
            2'd1:    byte_data = load_word[15:8];
            2'd2:    byte_data = load_word[23:16];
            default: byte_data = load_word[31:24];
        endcase
    end

    // bit 0 ignored for halfwords
    assign half_data = bus_r.addr_low[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        case (bus_r.ld_size)
            LD_BYTE: mem_result = {{24{bus_r.ld_signed & byte_data[7]}}, byte_data};
            LD_HALF: mem_result = {{16{bus_r.ld_signed & half_data[15]}}, half_data};
            default: mem_result = load_word;
        endcase
    end

    always_comb begin
        ws_bus.dest         = bus_r.dest;
        ws_bus.gr_we        = bus_r.gr_we;
        ws_bus.final_result = bus_r.res_from_mem ? mem_result : bus_r.alu_result;
    end

    assign ws.valid = ms_valid;
    assign ws.bus   = ws_bus;
endmodule

//--- design/wb_stage.sv
module wb_stage (
    input  logic        clk,
    input  logic        reset,
    ms_ws_if.dst        ms,
    input  logic        out_ready,
    output logic        out_valid,
    output logic        out_we,
    output logic [4:0]  out_dest,
    output logic [31:0] out_result
);
    logic ws_valid;
    logic ws_allowin;
    logic [4:0]  dest_r;
    logic        gr_we_r;
    logic [31:0] result_r;

    // consumer acts as the next stage
    assign ws_allowin = !ws_valid || out_ready;
    assign ms.allowin = ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms.valid;
        end
        if (ms.valid && ws_allowin) begin
            dest_r   <= ms.bus.dest;
            gr_we_r  <= ms.bus.gr_we;
            result_r <= ms.bus.final_result;
        end
    end

    assign out_valid  = ws_valid;
    // bubbles never show a write
    assign out_we     = ws_valid && gr_we_r;
    assign out_dest   = dest_r;
    assign out_result = result_r;
endmodule

//--- design/lsu_pipe.sv
module lsu_pipe import lsu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_allowin,
    input  insn_t       in_insn,
    input  logic [31:0] in_src1,
    input  logic [31:0] in_src2,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        out_we,
    output logic [4:0]  out_dest,
    output logic [31:0] out_result
);
    logic              ram_en;
    logic [3:0]        ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [31:0]       ram_wdata;
    logic [31:0]       ram_rdata;

    es_ms_if es_ms ();
    ms_ws_if ms_ws ();

    exe_stage #(.ADDR_W(ADDR_W)) u_exe (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_insn    (in_insn),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .ms         (es_ms.src),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    data_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem (
        .clk   (clk),
        .reset (reset),
        .es    (es_ms.dst),
        .ws    (ms_ws.src),
        .rdata (ram_rdata)
    );

    wb_stage u_wb (
        .clk        (clk),
        .reset      (reset),
        .ms         (ms_ws.dst),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_we     (out_we),
        .out_dest   (out_dest),
        .out_result (out_result)
    );
endmodule

//--- sim/lsu_pipe_tb.sv
module lsu_pipe_tb import lsu_pkg::*; ();
    localparam int ADDR_W     = 8;
    localparam int N_INSN     = 600;
    localparam int STEADY_N   = 40;
    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT    = (N_INSN * 20 + 50) * CLK_PERIOD;

    typedef struct packed {
        logic        we;
        logic [4:0]  dest;
        logic [31:0] result;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_allowin;
    insn_t       in_insn;
    logic [31:0] in_src1;
    logic [31:0] in_src2;
    logic        out_valid;
    logic        out_ready;
    logic        out_we;
    logic [4:0]  out_dest;
    logic [31:0] out_result;

    logic [31:0] lfsr;
    logic [31:0] model_mem [0:2**ADDR_W-1];
    exp_t        exp_q [$];
    int          accepted;
    int          edge_idx;
    int          stall_left;
    logic        started;

    op_t op_list [14] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MUL_LO, OP_MUL_HI,
                          OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
                          OP_ST_B, OP_ST_H, OP_ST_W};

    lsu_pipe #(.ADDR_W(ADDR_W)) DUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_insn    (in_insn),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_we     (out_we),
        .out_dest   (out_dest),
        .out_result (out_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // expected output of one accepted instruction
    // stores update the memory copy in acceptance order
    task automatic predict(input insn_t insn, input logic [31:0] a, input logic [31:0] b);
        exp_t        e;
        logic [31:0] addr;
        logic [31:0] word;
        logic [63:0] prod;
        logic [7:0]  bt;
        logic [15:0] hw;
        int          wi;
        addr     = a + 32'(insn.m_fmt.imm);
        wi       = addr[ADDR_W+1:2];
        word     = model_mem[wi];
        bt       = word[8*addr[1:0] +: 8];
        hw       = word[16*addr[1] +: 16];
        prod     = 64'(a) * 64'(b);
        e.dest   = insn.r_fmt.rd;
        e.we     = 1'b1;
        e.result = addr;
        case (insn.r_fmt.op)
            OP_ADD:    e.result = a + b;
            OP_SUB:    e.result = a - b;
            OP_AND:    e.result = a & b;
            OP_OR:     e.result = a | b;
            OP_MUL_LO: e.result = prod[31:0];
            OP_MUL_HI: e.result = prod[63:32];
            OP_LD_B:   e.result = {{24{bt[7]}}, bt};
            OP_LD_BU:  e.result = {24'h0, bt};
            OP_LD_H:   e.result = {{16{hw[15]}}, hw};
            OP_LD_HU:  e.result = {16'h0, hw};
            OP_LD_W:   e.result = word;
            OP_ST_B:   model_mem[wi][8*addr[1:0] +: 8] = b[7:0];
            OP_ST_H:   model_mem[wi][16*addr[1] +: 16] = b[15:0];
            OP_ST_W:   model_mem[wi] = b;
            default:   e.result = 'x;
        endcase
        if (insn.r_fmt.op inside {OP_ST_B, OP_ST_H, OP_ST_W}) begin
            e.we = 1'b0;
        end
        exp_q.push_back(e);
    endtask

    task automatic drive_next_insn();
        insn_t       ni;
        op_t         op;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  target;
        draw_bits(4, r);
        op = op_list[r % 14];
        ni = '0;
        ni.r_fmt.op = op;
        draw_bits(5, r);
        ni.r_fmt.rd = r[4:0];
        draw_bits(5, r);
        ni.r_fmt.rj = r[4:0];
        draw_bits(32, b);
        if (op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
                       OP_ST_B, OP_ST_H, OP_ST_W}) begin
            // byte address inside a 16-word window aligned to the access size
            draw_bits(6, r);
            target = r[5:0];
            if (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) begin
                target[0] = 1'b0;
            end
            if (op inside {OP_LD_W, OP_ST_W}) begin
                target[1:0] = 2'b00;
            end
            draw_bits(6, a);
            ni.m_fmt.imm = {10'h0, target} - {10'h0, a[5:0]};
        end else begin
            draw_bits(5, r);
            ni.r_fmt.rk = r[4:0];
            draw_bits(32, a);
        end
        in_insn <= ni;
        in_src1 <= a;
        in_src2 <= b;
    endtask

    task automatic check_output();
        exp_t e;
        if (started) begin
            edge_idx++;
        end
        if (edge_idx >= 3 && edge_idx <= STEADY_N) begin
            assert (out_valid === 1'b1) else begin
                $display("Error at %0t: out_valid is %0b, expected 1", $time, out_valid);
                $display("Test FAILED");
                $fatal(1);
            end
        end
        if (out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("a result came out with no instruction outstanding");
                $display("Test FAILED");
                $fatal(1);
            end
            e = exp_q.pop_front();
            assert (out_we === e.we) else begin
                $display("Error at %0t: out_we is %0b, expected %0b", $time, out_we, e.we);
                $display("Test FAILED");
                $fatal(1);
            end
            assert (out_dest === e.dest) else begin
                $display("Error at %0t: out_dest is %0d, expected %0d",
                         $time, out_dest, e.dest);
                $display("Test FAILED");
                $fatal(1);
            end
            assert (out_result === e.result) else begin
                $display("Error at %0t: out_result is %h, expected %h",
                         $time, out_result, e.result);
                $display("Test FAILED");
                $fatal(1);
            end
        end
    endtask

    task automatic accept_input();
        if (in_valid && in_allowin) begin
            predict(in_insn, in_src1, in_src2);
            accepted++;
            if (!started) begin
                started  = 1'b1;
                edge_idx = 0;
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        if (accepted < STEADY_N) begin
            out_ready <= 1'b1;
        end else if (stall_left > 0) begin
            out_ready <= 1'b0;
            stall_left--;
        end else begin
            draw_bits(5, r);
            if (r == 0) begin
                // long stall to keep a load in mem_stage past its first cycle
                draw_bits(3, r);
                stall_left = 6 + r;
                out_ready <= 1'b0;
            end else begin
                out_ready <= (r[1:0] != 2'b00);
            end
        end
        // payload only changes when nothing is waiting
        if (!in_valid || in_allowin) begin
            if (accepted >= N_INSN) begin
                in_valid <= 1'b0;
            end else if (accepted < STEADY_N) begin
                in_valid <= 1'b1;
                drive_next_insn();
            end else begin
                draw_bits(2, r);
                if (r == 0) begin
                    in_valid <= 1'b0;
                end else begin
                    in_valid <= 1'b1;
                    drive_next_insn();
                end
            end
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout, the pipeline stopped delivering results");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_insn    = '0;
        in_src1    = '0;
        in_src2    = '0;
        out_ready  = 1'b0;
        lfsr       = 32'h5124_f0d2;
        accepted   = 0;
        edge_idx   = -1;
        stall_left = 0;
        started    = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            model_mem[i] = 32'h0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (out_valid === 1'b0) else begin
            $display("Error at %0t: out_valid is %0b, expected 0", $time, out_valid);
            $display("Test FAILED");
            $fatal(1);
        end
        assert (in_allowin === 1'b1) else begin
            $display("Error at %0t: in_allowin is %0b, expected 1", $time, in_allowin);
            $display("Test FAILED");
            $fatal(1);
        end
        while (!(accepted == N_INSN && exp_q.size() == 0)) begin
            check_output();
            accept_input();
            drive_inputs();
            @(posedge clk);
        end
        // nothing else may come out while draining
        repeat (6) begin
            assert (out_valid === 1'b0) else begin
                $display("an extra result came out after the last instruction");
                $display("Test FAILED");
                $fatal(1);
            end
            out_ready <= 1'b1;
            @(posedge clk);
        end
        $display("Test OK");
        $finish;
    end
endmodule

//--- lsu_pipe.f
design/lsu_pkg.sv
design/stage_if.sv
design/exe_stage.sv
design/data_ram.sv
design/mem_stage.sv
design/wb_stage.sv
design/lsu_pipe.sv
sim/lsu_pipe_tb.sv
